// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := btbTestbench
FILELIST  := btbSubsystem.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bankedEntryArray.sv ====
// Banked BTB entry storage
// FETCH_WIDTH registered read ports, INT_ISSUE_WIDTH write ports
// The bank comes from the lowest index bit

`timescale 1ns/1ps

module bankedEntryArray (
    input  logic clk,
    input  logic [pcAddressPkg::FETCH_WIDTH-1:0][btbGeometryPkg::INDEX_BITS-1:0] readIndex,
    output logic [pcAddressPkg::FETCH_WIDTH-1:0][btbGeometryPkg::ENTRY_BITS-1:0] readEntry,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0] writeEnable,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][btbGeometryPkg::INDEX_BITS-1:0] writeIndex,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][btbGeometryPkg::ENTRY_BITS-1:0] writeEntry
);
    import pcAddressPkg::*;
    import btbGeometryPkg::*;

    logic [ENTRY_BITS-1:0] bankMem [BANK_NUM][BANK_DEPTH];

    // Split each index into bank and row
    logic [FETCH_WIDTH-1:0][BANK_BITS-1:0] readBank;
    logic [FETCH_WIDTH-1:0][INDEX_BITS-BANK_BITS-1:0] readRow;
    logic [INT_ISSUE_WIDTH-1:0][BANK_BITS-1:0] writeBank;
    logic [INT_ISSUE_WIDTH-1:0][INDEX_BITS-BANK_BITS-1:0] writeRow;

    always_comb begin
        for (int r = 0; r < FETCH_WIDTH; r++) begin
            readBank[r] = readIndex[r][BANK_BITS-1:0];
            readRow[r] = readIndex[r][INDEX_BITS-1:BANK_BITS];
        end
        for (int w = 0; w < INT_ISSUE_WIDTH; w++) begin
            writeBank[w] = writeIndex[w][BANK_BITS-1:0];
            writeRow[w] = writeIndex[w][INDEX_BITS-1:BANK_BITS];
        end
    end

    // One write per bank per cycle, the arbiter guarantees it
    always_ff @(posedge clk) begin
        for (int w = 0; w < INT_ISSUE_WIDTH; w++) begin
            if (writeEnable[w]) begin
                bankMem[writeBank[w]][writeRow[w]] <= writeEntry[w];
            end
        end
    end

    // Synchronous reads, old data on a same-edge write
    always_ff @(posedge clk) begin
        for (int r = 0; r < FETCH_WIDTH; r++) begin
            readEntry[r] <= bankMem[readBank[r]][readRow[r]];
        end
    end

endmodule

// ==== branchTargetBuffer.sv ====
// Approximate-branch BTB top level
// Lookup path, write arbiter, deferral queue, banked storage, init sequencer

`timescale 1ns/1ps

module branchTargetBuffer (
    input  logic clk,
    input  logic rstN,
    input  logic [pcAddressPkg::PC_WIDTH-1:0] predNextPc,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0] resultValid,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0] resultIsAx,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][pcAddressPkg::PC_WIDTH-1:0] resultBranchPc,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][pcAddressPkg::PC_WIDTH-1:0] resultTarget,
    output logic [pcAddressPkg::FETCH_WIDTH-1:0] btbHit,
    output logic [pcAddressPkg::FETCH_WIDTH-1:0][pcAddressPkg::PC_WIDTH-1:0] btbTarget,
    output logic ready
);
    import pcAddressPkg::*;
    import btbGeometryPkg::*;

    logic [FETCH_WIDTH-1:0][INDEX_BITS-1:0] readIndex;
    logic [FETCH_WIDTH-1:0][ENTRY_BITS-1:0] readEntry;
    logic [INT_ISSUE_WIDTH-1:0] writeEnable;
    logic [INT_ISSUE_WIDTH-1:0][INDEX_BITS-1:0] writeIndex;
    logic [INT_ISSUE_WIDTH-1:0][ENTRY_BITS-1:0] writeEntry;
    logic push;
    logic [INDEX_BITS-1:0] pushIndex;
    logic [ENTRY_BITS-1:0] pushEntry;
    logic pop;
    logic [INDEX_BITS-1:0] headIndex;
    logic [ENTRY_BITS-1:0] headEntry;
    logic empty;
    logic full;
    logic clearing;
    logic [INDEX_BITS-1:0] clearIndex;

    btbLookup btbLookup_i (
        .clk, .rstN, .predNextPc, .clearing,
        .readIndex, .readEntry, .btbHit, .btbTarget
    );

    btbWriteArbiter btbWriteArbiter_i (
        .clearing, .clearIndex,
        .resultValid, .resultIsAx, .resultBranchPc, .resultTarget,
        .headIndex, .headEntry, .empty, .full,
        .push, .pushIndex, .pushEntry, .pop,
        .writeEnable, .writeIndex, .writeEntry
    );

    deferredWriteQueue deferredWriteQueue_i (
        .clk, .rstN, .push, .pushIndex, .pushEntry, .pop,
        .headIndex, .headEntry, .empty, .full
    );

    bankedEntryArray bankedEntryArray_i (
        .clk, .readIndex, .readEntry, .writeEnable, .writeIndex, .writeEntry
    );

    btbInitSequencer btbInitSequencer_i (
        .clk, .rstN, .clearing, .clearIndex, .ready
    );

endmodule

// ==== btbGeometryPkg.sv ====
// BTB geometry definitions
// Entry count, bank split, tag and compressed target widths
// Entry bit layout, deferral queue sizing, init FSM states

package btbGeometryPkg;

    // Entries and the index taken from PC bits 7:2
    localparam int ENTRY_NUM = 64;
    localparam int INDEX_BITS = 6;

    // Bank is the lowest index bit, row is the rest
    localparam int BANK_NUM = 2;
    localparam int BANK_BITS = 1;
    localparam int BANK_DEPTH = ENTRY_NUM / BANK_NUM;

    // Tag sits just above the index, PC bits 15:8
    localparam int TAG_BITS = 8;
    localparam int TAG_LSB = pcAddressPkg::OFFSET_BITS + INDEX_BITS;

    // Only the low part of the target is kept
    localparam int TARGET_BITS = 16;

    // Entry layout is {valid, tag, target}
    localparam int ENTRY_BITS = 1 + TAG_BITS + TARGET_BITS;
    localparam int ENTRY_VALID_BIT = ENTRY_BITS - 1;
    localparam int ENTRY_TAG_LSB = TARGET_BITS;

    // Deferral queue for bank-conflicted writes
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    // Post-reset clearing FSM
    typedef enum logic {
        initClear,
        initDone
    } initState;

endpackage

// ==== btbInitSequencer.sv ====
// Post-reset BTB clearing sequencer
// Walks every index once, then raises ready for good

`timescale 1ns/1ps

module btbInitSequencer (
    input  logic clk,
    input  logic rstN,
    output logic clearing,
    output logic [btbGeometryPkg::INDEX_BITS-1:0] clearIndex,
    output logic ready
);
    import btbGeometryPkg::*;

    initState state;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= initClear;
            clearIndex <= '0;
        end else begin
            case (state)
                initClear: begin
                    clearIndex <= clearIndex + 1'b1;
                    // Last entry is written on this edge
                    if (clearIndex == INDEX_BITS'(ENTRY_NUM - 1)) begin
                        state <= initDone;
                    end
                end
                initDone: begin
                    state <= initDone;
                end
                default: begin
                    state <= initClear;
                end
            endcase
        end
    end

    assign clearing = (state == initClear);
    assign ready = (state == initDone);

endmodule

// ==== btbLookup.sv ====
// BTB lookup path
// Forms one read index per fetch slot from the predicted next PC
// Holds slot PCs for a cycle, then compares tags and rebuilds targets

`timescale 1ns/1ps

module btbLookup (
    input  logic clk,
    input  logic rstN,
    input  logic [pcAddressPkg::PC_WIDTH-1:0] predNextPc,
    input  logic clearing,
    output logic [pcAddressPkg::FETCH_WIDTH-1:0][btbGeometryPkg::INDEX_BITS-1:0] readIndex,
    input  logic [pcAddressPkg::FETCH_WIDTH-1:0][btbGeometryPkg::ENTRY_BITS-1:0] readEntry,
    output logic [pcAddressPkg::FETCH_WIDTH-1:0] btbHit,
    output logic [pcAddressPkg::FETCH_WIDTH-1:0][pcAddressPkg::PC_WIDTH-1:0] btbTarget
);
    import pcAddressPkg::*;
    import btbGeometryPkg::*;

    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] slotPc;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] slotPcQ;
    logic lookupLive;

    // Consecutive slot addresses
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slotPc[i] = predNextPc + PC_WIDTH'(i * INSN_BYTES);
            readIndex[i] = slotPc[i][TAG_LSB-1:OFFSET_BITS];
        end
    end

    // Slot PCs line up with the read data one cycle later
    always_ff @(posedge clk) begin
        slotPcQ <= slotPc;
    end

    // Reads issued while clearing may see stale contents
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lookupLive <= 1'b0;
        end else begin
            lookupLive <= !clearing;
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            btbHit[i] = lookupLive && !clearing
                        && readEntry[i][ENTRY_VALID_BIT]
                        && (readEntry[i][ENTRY_TAG_LSB +: TAG_BITS]
                            == slotPcQ[i][TAG_LSB+TAG_BITS-1:TAG_LSB]);
            // Upper bits come from the fetch PC itself
            btbTarget[i] = {slotPcQ[i][PC_WIDTH-1:TARGET_BITS],
                            readEntry[i][TARGET_BITS-1:0]};
        end
    end

endmodule

// ==== btbSubsystem.f ====
pcAddressPkg.sv
btbGeometryPkg.sv
bankedEntryArray.sv
deferredWriteQueue.sv
btbWriteArbiter.sv
btbInitSequencer.sv
btbLookup.sv
branchTargetBuffer.sv
tbClockGen.sv
btbTestbench.sv

// ==== btbTestbench.sv ====
// BTB testbench
// Checks the post-reset clearing, then runs the commands listed in btbTests.txt
// Compares hit flags and rebuilt targets with the expected values

`timescale 1ns/1ps

module btbTestbench;
    import pcAddressPkg::*;
    import btbGeometryPkg::*;

    localparam int READY_TIMEOUT = 500;

    logic clk;
    logic rstN;
    logic [PC_WIDTH-1:0] predNextPc;
    logic [INT_ISSUE_WIDTH-1:0] resultValid;
    logic [INT_ISSUE_WIDTH-1:0] resultIsAx;
    logic [INT_ISSUE_WIDTH-1:0][PC_WIDTH-1:0] resultBranchPc;
    logic [INT_ISSUE_WIDTH-1:0][PC_WIDTH-1:0] resultTarget;
    logic [FETCH_WIDTH-1:0] btbHit;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] btbTarget;
    logic ready;

    int passCount;
    int failCount;
    bit setupError;

    tbClockGen tbClockGen_i (.clk);

    branchTargetBuffer branchTargetBuffer_i (
        .clk, .rstN, .predNextPc,
        .resultValid, .resultIsAx, .resultBranchPc, .resultTarget,
        .btbHit, .btbTarget, .ready
    );

    // Ready is sampled away from the rising edge, one sample per clearing cycle
    // No hits while clearing, ready rises after one cycle per entry
    task automatic waitForReady();
        int cycles;
        bit ok;
        cycles = 0;
        ok = 1'b1;
        @(negedge clk);
        if (ready !== 1'b0) begin
            $display("[ERROR] reset_init ready expected 0 actual %0b", ready);
            ok = 1'b0;
        end
        while (ready !== 1'b1 && cycles < READY_TIMEOUT) begin
            if (ok && btbHit !== '0) begin
                $display("[ERROR] reset_init hit while clearing expected 0 actual %0b", btbHit);
                ok = 1'b0;
            end
            @(negedge clk);
            cycles++;
        end
        if (ready !== 1'b1) begin
            $display("Timed out waiting for ready after reset");
            setupError = 1'b1;
        end else begin
            if (cycles != ENTRY_NUM) begin
                $display("[ERROR] reset_init ready cycles expected %0d actual %0d",
                         ENTRY_NUM, cycles);
                ok = 1'b0;
            end
            if (ok) begin
                passCount++;
                $display("PASS  reset_init");
            end else begin
                failCount++;
            end
        end
    endtask

    // Results are presented for one cycle and land at the following edge
    task automatic applyWrite(input logic [INT_ISSUE_WIDTH-1:0] valid,
                              input logic [INT_ISSUE_WIDTH-1:0] isAx,
                              input logic [INT_ISSUE_WIDTH-1:0][PC_WIDTH-1:0] branchPc,
                              input logic [INT_ISSUE_WIDTH-1:0][PC_WIDTH-1:0] target);
        @(posedge clk);
        resultValid <= valid;
        resultIsAx <= isAx;
        resultBranchPc <= branchPc;
        resultTarget <= target;
        @(posedge clk);
        resultValid <= '0;
        resultIsAx <= '0;
    endtask

    // Target is only meaningful when a hit is expected
    task automatic runLookup(input logic [8*24-1:0] name,
                             input logic [PC_WIDTH-1:0] pc,
                             input logic [FETCH_WIDTH-1:0] expHit,
                             input logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] expTarget);
        bit ok;
        ok = 1'b1;
        @(posedge clk);
        predNextPc <= pc;
        @(posedge clk);
        @(negedge clk);
        if (ready !== 1'b1) begin
            $display("[ERROR] %0s ready expected 1 actual %0b", name, ready);
            ok = 1'b0;
        end
        for (int s = 0; s < FETCH_WIDTH; s++) begin
            if (btbHit[s] !== expHit[s]) begin
                $display("[ERROR] %0s slot %0d hit expected %0b actual %0b",
                         name, s, expHit[s], btbHit[s]);
                ok = 1'b0;
            end else if (expHit[s] && btbTarget[s] !== expTarget[s]) begin
                $display("[ERROR] %0s slot %0d target expected %08h actual %08h",
                         name, s, expTarget[s], btbTarget[s]);
                ok = 1'b0;
            end
        end
        if (ok) begin
            passCount++;
            $display("PASS  %0s", name);
        end else begin
            failCount++;
        end
    endtask

    initial begin
        int fd;
        int code;
        int idleCycles;
        logic [8*160-1:0] lineBuf;
        logic [8*8-1:0] cmd;
        logic [8*24-1:0] name;
        logic [PC_WIDTH-1:0] pcVal;
        logic [31:0] validVal [2];
        logic [31:0] isAxVal [2];
        logic [31:0] branchVal [2];
        logic [31:0] targetVal [2];
        logic [31:0] hitVal [2];
        logic [31:0] expVal [2];

        rstN = 1'b0;
        predNextPc = '0;
        resultValid = '0;
        resultIsAx = '0;
        resultBranchPc = '0;
        resultTarget = '0;
        passCount = 0;
        failCount = 0;
        setupError = 1'b0;

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        waitForReady();

        if (!setupError) begin
            fd = $fopen("btbTests.txt", "r");
            if (fd == 0) begin
                $display("Could not open the test vector file btbTests.txt");
                setupError = 1'b1;
            end else begin
                while (!$feof(fd) && !setupError) begin
                    lineBuf = '0;
                    code = $fgets(lineBuf, fd);
                    code = $sscanf(lineBuf, "%s", cmd);
                    // Blank lines and comment lines carry no command
                    if (code == 1 && cmd != "#") begin
                        if (cmd == "W") begin
                            code = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h", cmd,
                                           validVal[0], isAxVal[0], branchVal[0], targetVal[0],
                                           validVal[1], isAxVal[1], branchVal[1], targetVal[1]);
                            applyWrite({validVal[1][0], validVal[0][0]},
                                       {isAxVal[1][0], isAxVal[0][0]},
                                       {branchVal[1], branchVal[0]},
                                       {targetVal[1], targetVal[0]});
                        end else if (cmd == "I") begin
                            code = $sscanf(lineBuf, "%s %d", cmd, idleCycles);
                            repeat (idleCycles) @(posedge clk);
                        end else if (cmd == "L") begin
                            code = $sscanf(lineBuf, "%s %s %h %h %h %h %h", cmd, name, pcVal,
                                           hitVal[0], expVal[0], hitVal[1], expVal[1]);
                            runLookup(name, pcVal, {hitVal[1][0], hitVal[0][0]},
                                      {expVal[1], expVal[0]});
                        end else begin
                            $display("Unknown command %0s in btbTests.txt", cmd);
                            setupError = 1'b1;
                        end
                    end
                end
                $fclose(fd);
            end
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && passCount > 0 && !setupError) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== btbTests.txt ====
# All numbers are hex except the idle cycle count
# W valid0 isAx0 branchPc0 target0 valid1 isAx1 branchPc1 target1
# I cycles
# L name pc expHit0 expTarget0 expHit1 expTarget1 (target checked only on a hit)

# Everything misses right after initialization
L init_miss_low 00000000 0 00000000 0 00000000
L init_miss_mid 00012340 0 00000000 0 00000000
L init_miss_high fffffffc 0 00000000 0 00000000

# Single write, upper target bits come from the lookup PC
W 1 1 00012340 7777abcd 0 0 00000000 00000000
L single_hit 00012340 1 0001abcd 0 00000000
L single_hit_upper 00552340 1 0055abcd 0 00000000

# Not approximate on lane 0, not valid on lane 1
W 1 0 00001080 00002222 0 1 00001084 00003333
L filtered_miss 00001080 0 00000000 0 00000000

# Opposite banks in the same cycle
W 1 1 00002008 00004444 1 1 0000200c 00005555
L split_bank_hit 00002008 1 00004444 1 00005555

# Same bank, lane 1 goes through the deferral queue
W 1 1 00003020 00006666 1 1 00003028 00007777
I 5
L same_bank_lane0 00003020 1 00006666 0 00000000
L same_bank_lane1 00003028 1 00007777 0 00000000

# Same index with another tag, then replacement
L tag_mismatch 00014540 0 00000000 0 00000000
W 1 1 00014540 0000beef 0 0 00000000 00000000
L replace_new 00014540 1 0001beef 0 00000000
L replace_old 00012340 0 00000000 0 00000000

// ==== btbWriteArbiter.sv ====
// BTB write port arbiter
// Qualifies approximate branch results and builds their entries
// Defers the lowest bank-conflicted lane and refills idle ports from the queue
// Owns port 0 during post-reset clearing

`timescale 1ns/1ps

module btbWriteArbiter (
    input  logic clearing,
    input  logic [btbGeometryPkg::INDEX_BITS-1:0] clearIndex,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0] resultValid,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0] resultIsAx,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][pcAddressPkg::PC_WIDTH-1:0] resultBranchPc,
    input  logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][pcAddressPkg::PC_WIDTH-1:0] resultTarget,
    input  logic [btbGeometryPkg::INDEX_BITS-1:0] headIndex,
    input  logic [btbGeometryPkg::ENTRY_BITS-1:0] headEntry,
    input  logic empty,
    input  logic full,
    output logic push,
    output logic [btbGeometryPkg::INDEX_BITS-1:0] pushIndex,
    output logic [btbGeometryPkg::ENTRY_BITS-1:0] pushEntry,
    output logic pop,
    output logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0] writeEnable,
    output logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][btbGeometryPkg::INDEX_BITS-1:0] writeIndex,
    output logic [pcAddressPkg::INT_ISSUE_WIDTH-1:0][btbGeometryPkg::ENTRY_BITS-1:0] writeEntry
);
    import pcAddressPkg::*;
    import btbGeometryPkg::*;

    logic [INT_ISSUE_WIDTH-1:0] laneEnable;
    logic [INT_ISSUE_WIDTH-1:0] laneConflict;
    logic [INT_ISSUE_WIDTH-1:0][INDEX_BITS-1:0] laneIndex;
    logic [INT_ISSUE_WIDTH-1:0][ENTRY_BITS-1:0] laneEntry;
    logic headConflict;
    logic popTaken;

    // Entry built from each result lane
    always_comb begin
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            laneEnable[i] = resultValid[i] && resultIsAx[i];
            laneIndex[i] = resultBranchPc[i][TAG_LSB-1:OFFSET_BITS];
            laneEntry[i] = {1'b1,
                            resultBranchPc[i][TAG_LSB+TAG_BITS-1:TAG_LSB],
                            resultTarget[i][TARGET_BITS-1:0]};
        end
    end

    // A lane conflicts with any earlier enabled lane in the same bank
    always_comb begin
        laneConflict = '0;
        for (int i = 1; i < INT_ISSUE_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                if (laneEnable[i] && laneEnable[j]
                        && laneIndex[i][BANK_BITS-1:0] == laneIndex[j][BANK_BITS-1:0]) begin
                    laneConflict[i] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        push = 1'b0;
        pushIndex = '0;
        pushEntry = '0;
        pop = 1'b0;
        popTaken = 1'b0;
        headConflict = 1'b0;

        // Direct writes for lanes free of conflict
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            writeEnable[i] = laneEnable[i] && !laneConflict[i];
            writeIndex[i] = laneIndex[i];
            writeEntry[i] = laneEntry[i];
        end

        // Lowest conflicting lane goes to the queue; lost if the queue is full
        for (int i = INT_ISSUE_WIDTH - 1; i >= 1; i--) begin
            if (laneConflict[i]) begin
                push = !full;
                pushIndex = laneIndex[i];
                pushEntry = laneEntry[i];
            end
        end

        // Queue head may use an idle port if its bank is not already written
        for (int j = 0; j < INT_ISSUE_WIDTH; j++) begin
            if (writeEnable[j] && writeIndex[j][BANK_BITS-1:0] == headIndex[BANK_BITS-1:0]) begin
                headConflict = 1'b1;
            end
        end
        if (!empty && !headConflict) begin
            for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                if (!popTaken && !writeEnable[i]) begin
                    popTaken = 1'b1;
                    writeEnable[i] = 1'b1;
                    writeIndex[i] = headIndex;
                    writeEntry[i] = headEntry;
                end
            end
        end
        pop = popTaken;

        // Clearing owns port 0 and silences everything else
        if (clearing) begin
            for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
                writeEnable[i] = (i == 0);
                writeIndex[i] = clearIndex;
                writeEntry[i] = '0;
            end
            push = 1'b0;
            pop = 1'b0;
        end
    end

endmodule

// ==== deferredWriteQueue.sv ====
// Deferral queue for bank-conflicted BTB writes
// Circular buffer with head and tail pointers and an occupancy count
// A push into a full queue is ignored

`timescale 1ns/1ps

module deferredWriteQueue (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  logic [btbGeometryPkg::INDEX_BITS-1:0] pushIndex,
    input  logic [btbGeometryPkg::ENTRY_BITS-1:0] pushEntry,
    input  logic pop,
    output logic [btbGeometryPkg::INDEX_BITS-1:0] headIndex,
    output logic [btbGeometryPkg::ENTRY_BITS-1:0] headEntry,
    output logic empty,
    output logic full
);
    import btbGeometryPkg::*;

    logic [INDEX_BITS-1:0] slotIndex [QUEUE_DEPTH];
    logic [ENTRY_BITS-1:0] slotEntry [QUEUE_DEPTH];

    logic [QUEUE_PTR_BITS-1:0] headPtr;
    logic [QUEUE_PTR_BITS-1:0] tailPtr;
    logic [QUEUE_COUNT_BITS-1:0] count;

    logic doPush;
    logic doPop;

    assign doPush = push && !full;
    assign doPop = pop && !empty;

    assign empty = (count == '0);
    assign full = (count == QUEUE_COUNT_BITS'(QUEUE_DEPTH));

    assign headIndex = slotIndex[headPtr];
    assign headEntry = slotEntry[headPtr];

    // Payload slots
    always_ff @(posedge clk) begin
        if (doPush) begin
            slotIndex[tailPtr] <= pushIndex;
            slotEntry[tailPtr] <= pushEntry;
        end
    end

    // Pointers wrap at the last slot
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= (tailPtr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= (headPtr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : headPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== pcAddressPkg.sv ====
// Program counter and pipeline width definitions
// Fetch slot stride, lookups per cycle and branch result lanes
// Byte offset dropped from a PC before it is used as an index

package pcAddressPkg;

    // Width of every instruction address
    localparam int PC_WIDTH = 32;

    // Byte distance between two neighbouring fetch slots
    localparam int INSN_BYTES = 4;

    // Lookups served per cycle, one per fetch slot
    localparam int FETCH_WIDTH = 2;

    // Branch result lanes coming back from the integer pipes
    localparam int INT_ISSUE_WIDTH = 2;

    // Low PC bits that are always zero for aligned instructions
    localparam int OFFSET_BITS = 2;

endpackage

// ==== tbClockGen.sv ====
// Testbench clock source
// Free-running clock with a 4 ns period

`timescale 1ns/1ps

module tbClockGen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule
